// File: all.f
rtl/zx_pkg.sv
rtl/zx_io_decoder.sv
rtl/zx_port_registers.sv
rtl/zx_address_mapper.sv
rtl/zx_memory_request.sv
rtl/zx_paging_top.sv
test/tb_clock_gen.sv
test/zx_paging_assertions.sv
test/zx_paging_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the paging unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module zx_paging_tb \
	-f all.f --Mdir obj_dir -o zx_paging_sim

output=$(./obj_dir/zx_paging_sim +verilator+error+limit+100 || true)
echo "$output"

if grep -qx "Test OK" <<< "$output"; then
	exit 0
fi
exit 1

// File: test/zx_paging_tb.sv
// Testbench for the paging unit: stimulus table, compare tasks, timeout and summary
`timescale 1ns/1ps
`default_nettype none

module zx_paging_tb import zx_pkg::*; ();

	localparam int POR_CYCLES   = 16;
	localparam int FORCE_CYCLES = 4;	// Reset length on a mode change
	localparam ula_out_t ULA_CLR = '0;
	localparam ula_out_t ULA_FE1 = '{border: 3'd5, ear: 1'b1, mic: 1'b1};
	localparam ula_out_t ULA_FE2 = '{border: 3'd2, ear: 1'b0, mic: 1'b0};

	typedef enum logic [1:0] {IO_WR, MEM_RD, MEM_WR} bus_kind_t;

	typedef struct packed {
		mem_mode_t   mode;
		bus_kind_t   kind;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [3:0]  target;	// ROM flag, then bank or ROM number
		logic        we;
		ula_out_t    ula;
		logic        screen;
		logic        motor;
	} test_row_t;

	logic      clk_sys;
	logic      por_reset;
	logic      force_reset;
	logic      reset;
	mem_mode_t mem_mode;
	cpu_bus_t  cpu;
	ram_req_t  ram;
	logic      ram_req;
	ula_out_t  ula;
	logic      screen_page;
	logic      motor;

	test_row_t rows[$];
	mem_mode_t cur_mode;
	integer    seed;
	int        errors;
	int        checks;
	int        mode_changes;
	int        asrt_fails;
	int        cycle_count = 0;
	int        cycle_limit = 0;

	assign reset = por_reset | force_reset;

	tb_clock_gen tb_clock_gen_inst (
		.clk_sys (clk_sys),
		.reset   (por_reset)
	);

	zx_paging_top zx_paging_top_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mem_mode    (mem_mode),
		.cpu         (cpu),
		.ram         (ram),
		.ram_req     (ram_req),
		.ula         (ula),
		.screen_page (screen_page),
		.motor       (motor)
	);

	function automatic void add_row(input mem_mode_t m, input bus_kind_t k,
			input logic [15:0] a, input logic [7:0] d, input logic [3:0] t, input logic w,
			input ula_out_t u, input logic s, input logic mo);
		rows.push_back('{mode: m, kind: k, addr: a, data: d, target: t, we: w, ula: u,
			screen: s, motor: mo});
	endfunction

	task automatic check_ram(input ram_req_t got, input ram_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: ram got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_ula(input ula_out_t got, input ula_out_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: ula got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic apply_row(input int idx);
		test_row_t  r;
		ram_req_t   exp_ram;
		logic [7:0] dout;
		r = rows[idx];
		if (r.mode != cur_mode) begin	// Mode is only taken during reset
			@(negedge clk_sys);
			mem_mode    = r.mode;
			force_reset = 1'b1;
			cpu.mreq    = 1'b1;	// Strobe that reset must swallow
			cpu.rd      = 1'b1;
			repeat (FORCE_CYCLES) @(negedge clk_sys);
			cpu         = '0;
			force_reset = 1'b0;
			cur_mode    = r.mode;
		end
		dout = (r.kind == MEM_WR) ? 8'($random(seed)) : r.data;
		exp_ram = '{addr: '{is_rom: r.target[3], page: r.target[2:0], offset: r.addr[13:0]},
			we: r.we, din: dout};
		@(negedge clk_sys);
		cpu.addr = r.addr;
		cpu.dout = dout;
		cpu.mreq = (r.kind != IO_WR);
		cpu.iorq = (r.kind == IO_WR);
		cpu.rd   = (r.kind == MEM_RD);
		cpu.wr   = (r.kind != MEM_RD);
		@(negedge clk_sys);	// One edge after the strobe rose
		if (r.kind == IO_WR) begin
			check_flag("ram_req", ram_req, 1'b0);
		end else if (!ram_req) begin
			errors++;
			$display("ERROR at %0t: row %0d produced no memory request", $time, idx);
		end else begin
			check_ram(ram, exp_ram);
		end
		repeat (2) @(negedge clk_sys);
		cpu = '0;
		repeat (2) @(negedge clk_sys);
		check_ula(ula, r.ula);
		check_flag("screen_page", screen_page, r.screen);
		check_flag("motor", motor, r.motor);
	endtask

	// ========================================================================
	// Stimulus table and main sequence
	// ========================================================================
	initial begin
		seed        = 19616;
		errors      = 0;
		checks      = 0;
		force_reset = 1'b0;
		cpu         = '0;

		// 128K after reset, then paging and lock
		add_row(MODE_128, MEM_RD, 16'h0123, 8'h00, 4'h8, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, MEM_RD, 16'h4567, 8'h00, 4'h5, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, MEM_RD, 16'h8ABC, 8'h00, 4'h2, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, MEM_RD, 16'hC001, 8'h00, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, MEM_WR, 16'h1000, 8'h00, 4'h8, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, IO_WR,  16'h7FFD, 8'h1B, 4'h0, 1'b0, ULA_CLR, 1'b1, 1'b0);
		add_row(MODE_128, MEM_RD, 16'hC200, 8'h00, 4'h3, 1'b0, ULA_CLR, 1'b1, 1'b0);
		add_row(MODE_128, MEM_RD, 16'h0200, 8'h00, 4'h9, 1'b0, ULA_CLR, 1'b1, 1'b0);
		add_row(MODE_128, IO_WR,  16'h7FFD, 8'h24, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);	// Lock
		add_row(MODE_128, IO_WR,  16'h7FFD, 8'h17, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, MEM_RD, 16'hC300, 8'h00, 4'h4, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, MEM_RD, 16'h0300, 8'h00, 4'h8, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_128, IO_WR,  16'h00FE, 8'h1D, 4'h0, 1'b0, ULA_FE1, 1'b0, 1'b0);
		// 48K ignores 7FFD
		add_row(MODE_48,  IO_WR,  16'h7FFD, 8'h1B, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_48,  MEM_RD, 16'hC400, 8'h00, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_48,  MEM_RD, 16'h0400, 8'h00, 4'h9, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_48,  MEM_WR, 16'h8000, 8'h00, 4'h2, 1'b1, ULA_CLR, 1'b0, 1'b0);
		// +3 ROM selection, motor, special configurations
		add_row(MODE_PLUS3, MEM_RD, 16'h0500, 8'h00, 4'h8, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, IO_WR,  16'h1FFD, 8'h0C, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b1);
		add_row(MODE_PLUS3, IO_WR,  16'h7FFD, 8'h10, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b1);
		add_row(MODE_PLUS3, MEM_RD, 16'h0600, 8'h00, 4'hB, 1'b0, ULA_CLR, 1'b0, 1'b1);
		add_row(MODE_PLUS3, MEM_WR, 16'h0700, 8'h00, 4'hB, 1'b0, ULA_CLR, 1'b0, 1'b1);
		add_row(MODE_PLUS3, IO_WR,  16'h1FFD, 8'h01, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'h0800, 8'h00, 4'h0, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'h4800, 8'h00, 4'h1, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'h8800, 8'h00, 4'h2, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'hC800, 8'h00, 4'h3, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, IO_WR,  16'h1FFD, 8'h03, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'h0900, 8'h00, 4'h4, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'hC900, 8'h00, 4'h7, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, IO_WR,  16'h1FFD, 8'h05, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'h0A00, 8'h00, 4'h4, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, MEM_WR, 16'hCA00, 8'h00, 4'h3, 1'b1, ULA_CLR, 1'b0, 1'b0);
		add_row(MODE_PLUS3, IO_WR,  16'h1FFD, 8'h0F, 4'h0, 1'b0, ULA_CLR, 1'b0, 1'b1);
		add_row(MODE_PLUS3, MEM_WR, 16'h4B00, 8'h00, 4'h7, 1'b1, ULA_CLR, 1'b0, 1'b1);
		add_row(MODE_PLUS3, MEM_RD, 16'h8B00, 8'h00, 4'h6, 1'b0, ULA_CLR, 1'b0, 1'b1);
		add_row(MODE_PLUS3, MEM_WR, 16'hCB00, 8'h00, 4'h3, 1'b1, ULA_CLR, 1'b0, 1'b1);
		// ULA port, and a port that decodes to nothing
		add_row(MODE_128, IO_WR,  16'h00FE, 8'h1D, 4'h0, 1'b0, ULA_FE1, 1'b0, 1'b0);
		add_row(MODE_128, IO_WR,  16'h3FFF, 8'h55, 4'h0, 1'b0, ULA_FE1, 1'b0, 1'b0);
		add_row(MODE_128, MEM_RD, 16'hC000, 8'h00, 4'h0, 1'b0, ULA_FE1, 1'b0, 1'b0);
		add_row(MODE_128, IO_WR,  16'h00FE, 8'h02, 4'h0, 1'b0, ULA_FE2, 1'b0, 1'b0);

		mem_mode     = rows[0].mode;
		cur_mode     = rows[0].mode;
		mode_changes = 0;
		for (int i = 1; i < rows.size(); i++) begin
			if (rows[i].mode != rows[i - 1].mode)
				mode_changes++;
		end
		cycle_limit = rows.size() * 8 + POR_CYCLES + mode_changes * FORCE_CYCLES + 50;

		@(negedge clk_sys);
		while (por_reset) @(negedge clk_sys);
		for (int i = 0; i < rows.size(); i++)
			apply_row(i);

		asrt_fails = zx_paging_top_inst.zx_paging_assertions_inst.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Timeout: run exceeded %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/zx_paging_assertions.sv
// Bound checks on the paging top level: request pulse width and reset values
`timescale 1ns/1ps
`default_nettype none

module zx_paging_assertions import zx_pkg::*; (
	input wire clk_sys,
	input wire reset,
	input wire ram_req,
	input wire ula_out_t ula
);

	int fail_count = 0;	// Read by the testbench at the end

	// Request is a single-cycle pulse
	req_single_pulse: assert property (@(posedge clk_sys) ram_req |=> !ram_req)
		else begin
			$error("ram_req high for two cycles in a row");
			fail_count++;
		end

	req_low_in_reset: assert property (@(posedge clk_sys) reset |=> !ram_req)
		else begin
			$error("ram_req high while reset is active");
			fail_count++;
		end

	ula_clear_in_reset: assert property (@(posedge clk_sys) reset |=> (ula == '0))
		else begin
			$error("ULA outputs not cleared by reset");
			fail_count++;
		end

endmodule

bind zx_paging_top zx_paging_assertions zx_paging_assertions_inst (
	.clk_sys (clk_sys),
	.reset   (reset),
	.ram_req (ram_req),
	.ula     (ula)
);

`default_nettype wire

// File: test/tb_clock_gen.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	localparam int RESET_CYCLES = 16;

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;	// 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;	// Released away from the sampling edge
	end

endmodule

`default_nettype wire

// File: rtl/zx_paging_top.sv
// Top level of the paging unit: decoder, registers, mapper and request stage
`timescale 1ns/1ps
`default_nettype none

module zx_paging_top import zx_pkg::*; (
	input wire clk_sys,
	input wire reset,
	input wire mem_mode_t mem_mode,
	input wire cpu_bus_t cpu,
	output ram_req_t ram,
	output logic ram_req,
	output ula_out_t ula,
	output logic screen_page,
	output logic motor
);

	port_write_t   pw;
	paging_state_t state;
	phys_addr_t    map_addr;
	logic          map_writable;

	zx_io_decoder zx_io_decoder_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu),
		.mode    (state.mode),	// Latched mode, not the raw selector
		.pw      (pw)
	);

	zx_port_registers zx_port_registers_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mem_mode    (mem_mode),
		.pw          (pw),
		.state       (state),
		.ula         (ula),
		.screen_page (screen_page),
		.motor       (motor)
	);

	zx_address_mapper zx_address_mapper_inst (
		.state        (state),
		.addr         (cpu.addr),
		.map_addr     (map_addr),
		.map_writable (map_writable)
	);

	zx_memory_request zx_memory_request_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu          (cpu),
		.map_addr     (map_addr),
		.map_writable (map_writable),
		.ram          (ram),
		.ram_req      (ram_req)
	);

endmodule

`default_nettype wire

// File: rtl/zx_memory_request.sv
// Memory strobe edge detector and registered RAM request
`timescale 1ns/1ps
`default_nettype none

module zx_memory_request import zx_pkg::*; (
	input wire clk_sys,
	input wire reset,
	input wire cpu_bus_t cpu,
	input wire phys_addr_t map_addr,
	input wire map_writable,
	output ram_req_t ram,
	output logic ram_req
);

	logic     strobe;
	logic     strobe_q;
	logic     strobe_rise;
	ram_req_t ram_q;
	logic     ram_req_q;

	assign strobe      = cpu.mreq & (cpu.rd | cpu.wr);
	assign strobe_rise = strobe & ~strobe_q;

	// Control side
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q  <= 1'b0;
			ram_req_q <= 1'b0;
		end else begin
			strobe_q  <= strobe;
			ram_req_q <= strobe_rise;	// Single pulse, no back-pressure
		end
	end

	// Request payload, held until the next strobe
	always_ff @(posedge clk_sys) begin
		if (strobe_rise) begin
			ram_q.addr <= map_addr;
			ram_q.we   <= cpu.wr & map_writable;	// ROM writes dropped here
			ram_q.din  <= cpu.dout;
		end
	end

	assign ram     = ram_q;
	assign ram_req = ram_req_q;

endmodule

`default_nettype wire

// File: rtl/zx_address_mapper.sv
// CPU address to physical RAM/ROM page mapping with write protection
`timescale 1ns/1ps
`default_nettype none

module zx_address_mapper import zx_pkg::*; (
	input wire paging_state_t state,
	input wire [15:0] addr,
	output phys_addr_t map_addr,
	output logic map_writable
);

	logic [1:0] slot;
	logic [1:0] cfg;
	logic       special;
	logic [2:0] rom_num;

	// +3 all-RAM tables: 0,1,2,3 / 4,5,6,7 / 4,5,6,3 / 4,7,6,3
	function automatic logic [2:0] special_bank(input logic [1:0] c, input logic [1:0] s);
		case (c)
			2'd0: special_bank = {1'b0, s};
			2'd1: special_bank = {1'b1, s};
			2'd2: special_bank = (s == 2'd3) ? 3'd3 : {1'b1, s};
			default: special_bank = (s == 2'd3) ? 3'd3 : ((s == 2'd1) ? 3'd7 : {1'b1, s});
		endcase
	endfunction

	assign slot    = addr[15:14];
	assign cfg     = {state.p1ffd.rom_hi, state.p1ffd.cfg_lo};
	assign special = (state.mode == MODE_PLUS3) && state.p1ffd.special;

	always_comb begin
		case (state.mode)
			MODE_48:    rom_num = ROM48_INDEX;
			MODE_PLUS3: rom_num = {1'b0, state.p1ffd.rom_hi, state.p7ffd.rom_sel};
			default:    rom_num = {2'b00, state.p7ffd.rom_sel};
		endcase
	end

	always_comb begin
		map_addr.offset = addr[13:0];
		map_addr.is_rom = 1'b0;
		map_writable    = 1'b1;
		if (special) begin
			map_addr.page = special_bank(cfg, slot);
		end else begin
			case (slot)
				2'd0: begin	// ROM slot, never written
					map_addr.is_rom = 1'b1;
					map_addr.page   = rom_num;
					map_writable    = 1'b0;
				end
				2'd1: map_addr.page = BANK_SCREEN;
				2'd2: map_addr.page = BANK_MID;
				default: map_addr.page = state.p7ffd.bank;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/zx_port_registers.sv
// Paging registers 7FFD and 1FFD, machine mode latch and ULA port outputs
`timescale 1ns/1ps
`default_nettype none

module zx_port_registers import zx_pkg::*; (
	input wire clk_sys,
	input wire reset,
	input wire mem_mode_t mem_mode,
	input wire port_write_t pw,
	output paging_state_t state,
	output ula_out_t ula,
	output logic screen_page,
	output logic motor
);

	mem_mode_t  mode_q;
	page_7ffd_t p7ffd_q;
	page_1ffd_t p1ffd_q;
	ula_out_t   ula_q;
	logic       paging_open;

	// 48K has no paging, and the lock bit holds until reset
	assign paging_open = (mode_q != MODE_48) && !p7ffd_q.lock;

	// ========================================================================
	// Paging registers
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode_q  <= mem_mode;	// Mode follows the selector while in reset
			p7ffd_q <= '0;
			p1ffd_q <= '0;
		end else begin
			case (pw.kind)
				PORT_7FFD: begin
					if (paging_open)
						p7ffd_q <= pw.data.p7ffd;
				end
				PORT_1FFD: begin
					if (paging_open)
						p1ffd_q <= pw.data.p1ffd;
				end
				default: ;
			endcase
		end
	end

	// ========================================================================
	// ULA port FE
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula_q <= '0;
		end else if (pw.kind == PORT_FE) begin
			ula_q.border <= pw.data.ula.border;
			ula_q.ear    <= pw.data.ula.ear;
			ula_q.mic    <= pw.data.ula.mic;
		end
	end

	assign state = '{mode: mode_q, p7ffd: p7ffd_q, p1ffd: p1ffd_q};
	assign ula   = ula_q;

	assign screen_page = p7ffd_q.screen;	// To video fetch
	assign motor       = p1ffd_q.motor;	// +3 disk motor

endmodule

`default_nettype wire

// File: rtl/zx_io_decoder.sv
// I/O write edge detector and paging/ULA port decoder
`timescale 1ns/1ps
`default_nettype none

module zx_io_decoder import zx_pkg::*; (
	input wire clk_sys,
	input wire reset,
	input wire cpu_bus_t cpu,
	input wire mem_mode_t mode,
	output port_write_t pw
);

	logic io_wr;
	logic io_wr_q;
	logic hit_7ffd;
	logic hit_1ffd;
	logic hit_fe;
	port_kind_t kind_d;
	port_kind_t kind_q;
	port_data_u data_q;

	assign io_wr = cpu.iorq & cpu.wr & ~cpu.m1;	// Not an interrupt ack

	// Partial decoding as on the real machines
	assign hit_7ffd = ~cpu.addr[15] & ~cpu.addr[1] & (cpu.addr[14] | (mode != MODE_PLUS3));
	assign hit_1ffd = (mode == MODE_PLUS3) & (cpu.addr[15:12] == 4'b0001) & ~cpu.addr[1];
	assign hit_fe   = ~cpu.addr[0];

	always_comb begin
		kind_d = PORT_NONE;
		if (hit_7ffd)
			kind_d = PORT_7FFD;
		else if (hit_1ffd)
			kind_d = PORT_1FFD;
		else if (hit_fe)
			kind_d = PORT_FE;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			kind_q  <= PORT_NONE;
		end else begin
			io_wr_q <= io_wr;
			kind_q  <= (io_wr & ~io_wr_q) ? kind_d : PORT_NONE;	// One cycle per write
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_wr & ~io_wr_q)
			data_q <= cpu.dout;
	end

	assign pw = '{kind: kind_q, data: data_q};

endmodule

`default_nettype wire

// File: rtl/zx_pkg.sv
// Shared types and memory map constants for the Spectrum paging unit
`default_nettype none

package zx_pkg;

	// ========================================================================
	// Machine and CPU bus
	// ========================================================================
	typedef enum logic [1:0] {
		MODE_128,
		MODE_48,	// Paging disabled
		MODE_PLUS3
	} mem_mode_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// ========================================================================
	// Port data layouts
	// ========================================================================
	typedef struct packed {
		logic [1:0] spare;
		logic       lock;	// Freezes paging until reset
		logic       rom_sel;
		logic       screen;	// Shadow screen in bank 7
		logic [2:0] bank;
	} page_7ffd_t;

	typedef struct packed {
		logic [3:0] spare;
		logic       motor;
		logic       rom_hi;	// Also high bit of special config
		logic       cfg_lo;
		logic       special;
	} page_1ffd_t;

	typedef struct packed {
		logic [2:0] spare;
		logic       ear;
		logic       mic;
		logic [2:0] border;
	} ula_port_t;

	// Same data byte, read according to the port it went to
	typedef union packed {
		page_7ffd_t p7ffd;
		page_1ffd_t p1ffd;
		ula_port_t  ula;
	} port_data_u;

	typedef enum logic [1:0] {PORT_NONE, PORT_7FFD, PORT_1FFD, PORT_FE} port_kind_t;

	typedef struct packed {
		port_kind_t kind;
		port_data_u data;
	} port_write_t;

	typedef struct packed {
		mem_mode_t  mode;
		page_7ffd_t p7ffd;
		page_1ffd_t p1ffd;
	} paging_state_t;

	// ========================================================================
	// Physical side
	// ========================================================================
	typedef struct packed {
		logic        is_rom;
		logic [2:0]  page;	// RAM bank or ROM number
		logic [13:0] offset;
	} phys_addr_t;

	typedef struct packed {
		phys_addr_t addr;
		logic       we;
		logic [7:0] din;
	} ram_req_t;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_out_t;

	localparam logic [2:0] BANK_SCREEN = 3'd5;
	localparam logic [2:0] BANK_MID    = 3'd2;
	localparam logic [2:0] ROM48_INDEX = 3'd1;	// BASIC ROM in 48K mode

endpackage

`default_nettype wire
